// File: Makefile
# Verilator run of the memory stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_stage \
		-f sim.f -o tb_mem_stage
	./obj_dir/tb_mem_stage | tee sim.log
	grep -q "No errors" sim.log
	! grep -q "Errors found" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/load_unit.sv
/*
 * load path and write-back select
 * extracts and extends the loaded lane, then picks the
 * register write value for the item
 */
`timescale 1ns/1ps

module load_unit (
    mem_stage_if.unit             stage,
    input  logic                  blocked,
    input  mem_bus_pkg::xword_t   dmem_rdata,
    output logic                  out_valid,
    output mem_bus_pkg::xword_t   out_pc,
    output logic                  wb_wen,
    output mem_isa_pkg::reg_idx_t wb_rd,
    output mem_bus_pkg::xword_t   wb_data
);
    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    logic [OFS_W-1:0] ofs;
    xword_t           lane;
    logic             sign_ext;
    logic             half_ok;
    logic             word_ok;
    xword_t           load_data;

    assign ofs      = stage.alu_result[OFS_W-1:0];
    assign lane     = dmem_rdata >> (ofs * BYTE_W);  // addressed byte now at bit 0
    assign sign_ext = OPS_SIGNED[stage.op];
    assign half_ok  = (ofs & HALF_ALIGN) == '0;
    assign word_ok  = (ofs & WORD_ALIGN) == '0;

    always_comb begin
        load_data = '0;
        case (stage.op)
            OP_LB, OP_LBU: begin
                load_data = {{(XLEN-BYTE_W){sign_ext & lane[BYTE_W-1]}},
                             lane[BYTE_W-1:0]};
            end
            OP_LH, OP_LHU: begin
                if (half_ok) begin
                    load_data = {{(XLEN-HALF_W){sign_ext & lane[HALF_W-1]}},
                                 lane[HALF_W-1:0]};
                end
            end
            OP_LW, OP_LWU: begin
                if (word_ok) begin
                    load_data = {{(XLEN-WORD_W){sign_ext & lane[WORD_W-1]}},
                                 lane[WORD_W-1:0]};
                end
            end
            OP_LD: load_data = dmem_rdata;
            default: ;
        endcase
    end

    // register write value
    always_comb begin
        case (stage.op)
            OP_ALU:  wb_data = stage.alu_result;
            OP_LINK: wb_data = stage.pc + LINK_OFFSET;  // return address
            OP_CSR:  wb_data = stage.src2;
            default: wb_data = OPS_LOAD[stage.op] ? load_data : '0;
        endcase
    end

    // nothing leaves while memory is still pending
    assign out_valid = stage.valid & ~blocked;
    assign wb_wen    = stage.valid & ~blocked & OPS_WB[stage.op];
    assign out_pc    = stage.pc;
    assign wb_rd     = stage.rd;

endmodule

// File: hdl/mem_bus_pkg.sv
/*
 * data memory port definitions
 * word and strobe types, byte lane sizes and alignment masks
 */
package mem_bus_pkg;

    localparam int XLEN   = 64;
    localparam int BYTE_W = 8;
    localparam int HALF_W = 16;
    localparam int WORD_W = 32;
    localparam int STRB_W = XLEN / BYTE_W;
    localparam int OFS_W  = 3;  // byte offset inside a doubleword

    typedef logic [XLEN-1:0]   xword_t;
    typedef logic [STRB_W-1:0] strb_t;

    localparam xword_t LINK_OFFSET = 64'd4;

    // offset bits that must be zero for a naturally aligned access
    localparam logic [OFS_W-1:0] HALF_ALIGN = 3'b001;
    localparam logic [OFS_W-1:0] WORD_ALIGN = 3'b011;

endpackage

// File: hdl/mem_isa_pkg.sv
/*
 * memory stage operation set
 * operation enum, register index type and per-op class masks
 */
package mem_isa_pkg;

    localparam int OP_W      = 5;
    localparam int OP_SPACE  = 2 ** OP_W;  // one mask bit per encoding
    localparam int REG_IDX_W = 5;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [OP_W-1:0] {
        OP_NONE,
        OP_ALU,
        OP_LINK,  // jal / jalr, writes pc+4
        OP_CSR,   // old csr value rides in src2
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LD,
        OP_LBU,
        OP_LHU,
        OP_LWU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SD
    } mem_op_t;

    // class masks, indexed by the op encoding
    localparam logic [OP_SPACE-1:0] OPS_LOAD =
        (OP_SPACE'(1) << OP_LB)  | (OP_SPACE'(1) << OP_LH)  | (OP_SPACE'(1) << OP_LW) |
        (OP_SPACE'(1) << OP_LD)  | (OP_SPACE'(1) << OP_LBU) | (OP_SPACE'(1) << OP_LHU) |
        (OP_SPACE'(1) << OP_LWU);
    localparam logic [OP_SPACE-1:0] OPS_STORE =
        (OP_SPACE'(1) << OP_SB) | (OP_SPACE'(1) << OP_SH) |
        (OP_SPACE'(1) << OP_SW) | (OP_SPACE'(1) << OP_SD);
    localparam logic [OP_SPACE-1:0] OPS_SIGNED =
        (OP_SPACE'(1) << OP_LB) | (OP_SPACE'(1) << OP_LH) | (OP_SPACE'(1) << OP_LW);
    // everything that ends in a register write
    localparam logic [OP_SPACE-1:0] OPS_WB = OPS_LOAD |
        (OP_SPACE'(1) << OP_ALU) | (OP_SPACE'(1) << OP_LINK) | (OP_SPACE'(1) << OP_CSR);

endpackage

// File: hdl/mem_stage.sv
/*
 * memory access stage, top level
 * stage register plus store and load paths behind a
 * plain request/ready data memory port
 */
`timescale 1ns/1ps

module mem_stage (
    input  logic                  clk,
    input  logic                  rst,

    // from execute
    input  logic                  in_valid,
    input  mem_bus_pkg::xword_t   in_pc,
    input  mem_isa_pkg::mem_op_t  in_op,
    input  mem_isa_pkg::reg_idx_t in_rd,
    input  mem_isa_pkg::reg_idx_t in_rs2,
    input  mem_bus_pkg::xword_t   in_alu_result,
    input  mem_bus_pkg::xword_t   in_src2,
    output logic                  in_ready,

    // to write-back
    output logic                  out_valid,
    output mem_bus_pkg::xword_t   out_pc,
    output logic                  wb_wen,
    output mem_isa_pkg::reg_idx_t wb_rd,
    output mem_bus_pkg::xword_t   wb_data,
    input  logic                  out_ready,

    // forwarding from write-back
    input  logic                  fwd_wen,
    input  mem_isa_pkg::reg_idx_t fwd_rd,
    input  mem_bus_pkg::xword_t   fwd_data,

    // data memory
    output logic                  dmem_req,
    output logic                  dmem_we,
    output mem_bus_pkg::xword_t   dmem_addr,
    output mem_bus_pkg::xword_t   dmem_wdata,
    output mem_bus_pkg::strb_t    dmem_wstrb,
    input  mem_bus_pkg::xword_t   dmem_rdata,
    input  logic                  dmem_ready
);

    logic blocked;  // access outstanding

    mem_stage_if u_stage_if ();

    mem_stage_reg u_stage_reg (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_rs2        (in_rs2),
        .in_alu_result (in_alu_result),
        .in_src2       (in_src2),
        .dmem_ready    (dmem_ready),
        .out_ready     (out_ready),
        .in_ready      (in_ready),
        .blocked       (blocked),
        .dmem_req      (dmem_req),
        .stage         (u_stage_if.stage)
    );

    store_unit u_store_unit (
        .stage      (u_stage_if.unit),
        .fwd_wen    (fwd_wen),
        .fwd_rd     (fwd_rd),
        .fwd_data   (fwd_data),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (dmem_wstrb)
    );

    load_unit u_load_unit (
        .stage      (u_stage_if.unit),
        .blocked    (blocked),
        .dmem_rdata (dmem_rdata),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .wb_wen     (wb_wen),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

// File: hdl/mem_stage_if.sv
/*
 * registered memory stage item
 * carried from the stage register to the store and load units
 */
`timescale 1ns/1ps

interface mem_stage_if;
    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    logic     valid;
    xword_t   pc;
    mem_op_t  op;
    reg_idx_t rd;
    reg_idx_t rs2;
    xword_t   alu_result;  // doubles as the memory address
    xword_t   src2;

    modport stage (
        output valid, pc, op, rd, rs2, alu_result, src2
    );

    modport unit (
        input valid, pc, op, rd, rs2, alu_result, src2
    );

endinterface

// File: hdl/mem_stage_reg.sv
/*
 * memory stage register
 * holds one item, stalls on an unfinished memory access,
 * and raises the data memory request
 */
`timescale 1ns/1ps

module mem_stage_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  mem_bus_pkg::xword_t   in_pc,
    input  mem_isa_pkg::mem_op_t  in_op,
    input  mem_isa_pkg::reg_idx_t in_rd,
    input  mem_isa_pkg::reg_idx_t in_rs2,
    input  mem_bus_pkg::xword_t   in_alu_result,
    input  mem_bus_pkg::xword_t   in_src2,
    input  logic                  dmem_ready,
    input  logic                  out_ready,
    output logic                  in_ready,
    output logic                  blocked,
    output logic                  dmem_req,
    mem_stage_if.stage            stage
);
    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    logic     valid_q;
    xword_t   pc_q;
    mem_op_t  op_q;
    reg_idx_t rd_q;
    reg_idx_t rs2_q;
    xword_t   alu_q;
    xword_t   src2_q;
    logic     mem_access;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;  // bubbles are captured too
        end
    end

    // payload follows valid, held while stalled
    always_ff @(posedge clk) begin
        if (in_ready) begin
            pc_q   <= in_pc;
            op_q   <= in_op;
            rd_q   <= in_rd;
            rs2_q  <= in_rs2;
            alu_q  <= in_alu_result;
            src2_q <= in_src2;
        end
    end

    assign mem_access = OPS_LOAD[op_q] | OPS_STORE[op_q];
    assign dmem_req   = valid_q & mem_access;
    assign blocked    = dmem_req & ~dmem_ready;  // waiting on memory
    assign in_ready   = blocked ? 1'b0 : out_ready;

    assign stage.valid      = valid_q;
    assign stage.pc         = pc_q;
    assign stage.op         = op_q;
    assign stage.rd         = rd_q;
    assign stage.rs2        = rs2_q;
    assign stage.alu_result = alu_q;
    assign stage.src2       = src2_q;

endmodule

// File: hdl/store_unit.sv
/*
 * store path
 * forwards the store operand from write-back and aligns
 * store data and byte strobe to the addressed lane
 */
`timescale 1ns/1ps

module store_unit (
    mem_stage_if.unit             stage,
    input  logic                  fwd_wen,
    input  mem_isa_pkg::reg_idx_t fwd_rd,
    input  mem_bus_pkg::xword_t   fwd_data,
    output logic                  dmem_we,
    output mem_bus_pkg::xword_t   dmem_addr,
    output mem_bus_pkg::xword_t   dmem_wdata,
    output mem_bus_pkg::strb_t    dmem_wstrb
);
    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    logic             fwd_hit;
    xword_t           store_src;
    logic [OFS_W-1:0] ofs;
    logic [OFS_W-1:0] lane_ofs;
    logic [OFS_W-1:0] align_mask;
    strb_t            size_strb;
    xword_t           size_bits;
    logic             misaligned;

    // x0 never forwards
    assign fwd_hit   = fwd_wen && (fwd_rd == stage.rs2) && (stage.rs2 != '0);
    assign store_src = fwd_hit ? fwd_data : stage.src2;

    assign ofs       = stage.alu_result[OFS_W-1:0];
    assign dmem_addr = stage.alu_result;
    assign dmem_we   = stage.valid & OPS_STORE[stage.op];

    // access size as a strobe at lane 0
    always_comb begin
        size_strb  = '0;
        align_mask = '0;
        lane_ofs   = ofs;
        case (stage.op)
            OP_SB: size_strb = strb_t'(8'h01);
            OP_SH: begin
                size_strb  = strb_t'(8'h03);
                align_mask = HALF_ALIGN;
            end
            OP_SW: begin
                size_strb  = strb_t'(8'h0f);
                align_mask = WORD_ALIGN;
            end
            OP_SD: begin
                size_strb = '1;
                lane_ofs  = '0;  // whole doubleword, low offset bits ignored
            end
            default: ;
        endcase
    end

    assign misaligned = |(ofs & align_mask);

    // strobe bits widened to byte masks
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            size_bits[i*BYTE_W +: BYTE_W] = {BYTE_W{size_strb[i]}};
        end
    end

    always_comb begin
        if (misaligned) begin
            dmem_wstrb = '0;
            dmem_wdata = '0;
        end else begin
            dmem_wstrb = size_strb << lane_ofs;
            dmem_wdata = (store_src & size_bits) << (lane_ofs * BYTE_W);
        end
    end

endmodule

// File: sim.f
hdl/mem_isa_pkg.sv
hdl/mem_bus_pkg.sv
hdl/mem_stage_if.sv
hdl/mem_stage_reg.sv
hdl/store_unit.sv
hdl/load_unit.sv
hdl/mem_stage.sv
sim/mem_stage_asserts.sv
sim/tb_mem_stage.sv

// File: sim/mem_stage_asserts.sv
/*
 * stage register protocol checks
 * stall, hold and reset behaviour of the memory request
 */
`timescale 1ns/1ps

module mem_stage_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  in_ready,
    input logic                  dmem_ready,
    input logic                  dmem_req,
    input logic                  valid_q,
    input mem_bus_pkg::xword_t   pc_q,
    input mem_isa_pkg::mem_op_t  op_q,
    input mem_isa_pkg::reg_idx_t rd_q,
    input mem_isa_pkg::reg_idx_t rs2_q,
    input mem_bus_pkg::xword_t   alu_q,
    input mem_bus_pkg::xword_t   src2_q
);

    // pending access seen on the memory port itself
    a_no_accept_blocked: assert property (@(posedge clk)
        dmem_req && !dmem_ready |-> !in_ready)
        else $error("in_ready high while the stage waits on memory");

    // held item must not move
    a_item_held: assert property (@(posedge clk) disable iff (rst)
        !in_ready |=> $stable(valid_q) && $stable(pc_q) && $stable(op_q) &&
                      $stable(rd_q) && $stable(rs2_q) && $stable(alu_q) &&
                      $stable(src2_q))
        else $error("stage item changed while in_ready was low");

    a_idle_after_reset: assert property (@(posedge clk) rst |=> !dmem_req)
        else $error("memory request high right after reset");

endmodule

bind mem_stage_reg mem_stage_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .in_ready   (in_ready),
    .dmem_ready (dmem_ready),
    .dmem_req   (dmem_req),
    .valid_q    (valid_q),
    .pc_q       (pc_q),
    .op_q       (op_q),
    .rd_q       (rd_q),
    .rs2_q      (rs2_q),
    .alu_q      (alu_q),
    .src2_q     (src2_q)
);

// File: sim/tb_mem_stage.sv
/*
 * memory stage testbench
 * applies a table of ops one at a time against a doubleword memory
 * model, with random ready levels on both sides of the stage
 */
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int     MAX_ROWS  = 64;
    localparam int     MEM_WORDS = 16;
    localparam xword_t PC_BASE   = 64'h8000_0000;
    localparam xword_t SRC       = 64'h1122_3344_5566_7788;  // default store operand

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid, in_ready, out_valid, out_ready, wb_wen;
    xword_t   in_pc, in_alu_result, in_src2, out_pc, wb_data, fwd_data;
    mem_op_t  in_op;
    reg_idx_t in_rd, in_rs2, wb_rd, fwd_rd;
    logic     fwd_wen, dmem_req, dmem_we, dmem_ready;
    xword_t   dmem_addr, dmem_wdata, dmem_rdata;
    strb_t    dmem_wstrb;

    // stimulus table with one entry per test
    string    name_t [MAX_ROWS];
    mem_op_t  op_t [MAX_ROWS];
    xword_t   pc_t [MAX_ROWS], addr_t [MAX_ROWS], src2_t [MAX_ROWS], fwd_data_t [MAX_ROWS];
    xword_t   exp_data_t [MAX_ROWS], exp_wdata_t [MAX_ROWS];
    strb_t    exp_strb_t [MAX_ROWS];
    reg_idx_t rd_t [MAX_ROWS], rs2_t [MAX_ROWS], fwd_rd_t [MAX_ROWS];
    logic     fwd_wen_t [MAX_ROWS];
    int       stall_t [MAX_ROWS];

    int       n_rows = 0;
    int       fails = 0;
    int       row_err;
    int       cycle_cnt = 0;
    int       cycle_limit = MAX_ROWS * 20;
    integer   seed = 32'hd574_cefa;
    xword_t   mem [MEM_WORDS];

    mem_stage u_mem_stage (.*);

    always #20 clk = ~clk;

    // data memory model of 16 doublewords
    assign dmem_rdata = mem[dmem_addr[6:3]];

    always @(posedge clk) begin
        if (dmem_req && dmem_we && dmem_ready) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (dmem_wstrb[b]) begin
                    mem[dmem_addr[6:3]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [7:0] fill_byte(input xword_t a);
        return 8'(a * 64'd37 + 64'd91);  // every address bit matters
    endfunction

    function automatic int op_bytes(input mem_op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_LWU, OP_SW: return 4;
            default:              return 8;
        endcase
    endfunction

    function automatic logic is_store(input mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    endfunction

    function automatic logic is_mem(input mem_op_t op);
        return is_store(op) || (op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU});
    endfunction

    // expected load result assembled byte by byte from the fill pattern
    function automatic xword_t ref_load(input mem_op_t op, input xword_t a);
        int     n;
        xword_t v;
        n = op_bytes(op);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = fill_byte(a + xword_t'(i));
        end
        if ((op inside {OP_LB, OP_LH, OP_LW}) && v[8*n-1]) begin
            for (int i = 8*n; i < XLEN; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic add_row(input string name, input mem_op_t op, input xword_t addr,
                           input xword_t src2, input xword_t exp_data,
                           input strb_t exp_strb, input xword_t exp_wdata);
        name_t[n_rows]      = name;
        op_t[n_rows]        = op;
        pc_t[n_rows]        = PC_BASE + xword_t'(4 * n_rows);
        addr_t[n_rows]      = addr;
        src2_t[n_rows]      = src2;
        rd_t[n_rows]        = reg_idx_t'(n_rows % 31 + 1);
        rs2_t[n_rows]       = '0;
        fwd_wen_t[n_rows]   = 1'b0;
        fwd_rd_t[n_rows]    = '0;
        fwd_data_t[n_rows]  = '0;
        exp_data_t[n_rows]  = exp_data;
        exp_strb_t[n_rows]  = exp_strb;
        exp_wdata_t[n_rows] = exp_wdata;
        stall_t[n_rows]     = 0;
        n_rows++;
    endtask

    // forwarding fields of the last row
    task automatic set_fwd(input reg_idx_t rs2, input logic wen, input reg_idx_t rd,
                           input xword_t data);
        rs2_t[n_rows-1]      = rs2;
        fwd_wen_t[n_rows-1]  = wen;
        fwd_rd_t[n_rows-1]   = rd;
        fwd_data_t[n_rows-1] = data;
    endtask

    task automatic build_table();
        mem_op_t lops [7];
        mem_op_t lop;
        string   nm;
        int      sz;
        xword_t  a;
        lops = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
        add_row("alu", OP_ALU, 64'h0000_1234_5678_9abc, SRC, 64'h0000_1234_5678_9abc, '0, '0);
        add_row("link", OP_LINK, 64'h0abc, SRC, PC_BASE + 64'd8, '0, '0);  // row 1 has pc base+4
        add_row("csr", OP_CSR, 64'h0300, 64'hdead_beef_0000_0042, 64'hdead_beef_0000_0042,
                '0, '0);
        for (int o = 0; o < 8; o++) begin
            add_row($sformatf("sb_ofs%0d", o), OP_SB, xword_t'(64'h40 + o), SRC, '0,
                    strb_t'(8'h01 << o), xword_t'(64'h88) << (8*o));
        end
        for (int o = 0; o < 8; o += 2) begin
            add_row($sformatf("sh_ofs%0d", o), OP_SH, xword_t'(64'h48 + o), SRC, '0,
                    strb_t'(8'h03 << o), xword_t'(64'h7788) << (8*o));
        end
        for (int o = 0; o < 8; o += 4) begin
            add_row($sformatf("sw_ofs%0d", o), OP_SW, xword_t'(64'h50 + o), SRC, '0,
                    strb_t'(8'h0f << o), xword_t'(64'h5566_7788) << (8*o));
        end
        add_row("sd_ofs0", OP_SD, 64'h58, SRC, '0, 8'hff, SRC);
        add_row("sh_misaligned", OP_SH, 64'h61, SRC, '0, '0, '0);
        add_row("sw_misaligned", OP_SW, 64'h66, SRC, '0, '0, '0);
        for (int i = 0; i < 7; i++) begin
            lop = lops[i];
            nm  = lop.name();
            sz  = op_bytes(lop);
            for (int o = 0; o < 8; o += sz) begin
                a = xword_t'(8*i + o);
                add_row($sformatf("%s_ofs%0d", nm.tolower(), o), lop, a, SRC,
                        ref_load(lop, a), '0, '0);
            end
        end
        add_row("sd_fwd", OP_SD, 64'h70, SRC, '0, 8'hff, 64'hcafe_f00d_1234_5678);
        set_fwd(5'd7, 1'b1, 5'd7, 64'hcafe_f00d_1234_5678);
        add_row("sd_fwd_x0", OP_SD, 64'h78, SRC, '0, 8'hff, SRC);
        set_fwd(5'd0, 1'b1, 5'd0, 64'hcafe_f00d_1234_5678);
        add_row("sd_fwd_off", OP_SD, 64'h60, SRC, '0, 8'hff, SRC);
        set_fwd(5'd7, 1'b0, 5'd7, 64'hcafe_f00d_1234_5678);
        add_row("sb_fwd", OP_SB, 64'h75, SRC, '0, 8'h20, 64'h0000_5a00_0000_0000);
        set_fwd(5'd9, 1'b1, 5'd9, 64'h0000_0000_0000_c35a);
        add_row("lw_stall", OP_LW, 64'h34, SRC, ref_load(OP_LW, 64'h34), '0, '0);
        stall_t[n_rows-1] = 4;
        add_row("sd_stall", OP_SD, 64'h68, 64'h0123_4567_89ab_cdef, '0, 8'hff,
                64'h0123_4567_89ab_cdef);
        stall_t[n_rows-1] = 3;
    endtask

    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #2;
        rnd        = $random(seed);
        dmem_ready = rnd[0];
        out_ready  = (rnd[2:1] != 2'b00);  // mostly ready
    endtask

    task automatic compare(input string name, input string what, input xword_t exp,
                           input xword_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected %h actual %h", name, what, exp, act);
            row_err++;
        end
    endtask

    task automatic run_row(input int r);
        logic     accepted;
        logic     done;
        logic     saw_req;
        logic     got_wen, got_req, got_we;
        xword_t   got_data, got_pc, got_wdata, got_addr;
        strb_t    got_strb;
        reg_idx_t got_rd;
        row_err       = 0;
        saw_req       = 1'b0;
        in_valid      = 1'b1;
        in_pc         = pc_t[r];
        in_op         = op_t[r];
        in_rd         = rd_t[r];
        in_rs2        = rs2_t[r];
        in_alu_result = addr_t[r];
        in_src2       = src2_t[r];
        fwd_wen       = fwd_wen_t[r];
        fwd_rd        = fwd_rd_t[r];
        fwd_data      = fwd_data_t[r];
        accepted      = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            next_cycle();
        end
        in_valid = 1'b0;
        in_op    = OP_NONE;
        if (stall_t[r] > 0) begin
            dmem_ready = 1'b0;
            repeat (stall_t[r]) begin
                @(negedge clk);
                if (in_ready || out_valid) begin
                    $display("%s: stage let an item through while memory was not ready",
                             name_t[r]);
                    row_err++;
                end
                @(posedge clk);
                #2;
            end
        end
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (dmem_req && !is_mem(op_t[r])) begin
                saw_req = 1'b1;
            end
            if (out_valid && out_ready) begin
                done      = 1'b1;
                got_data  = wb_data;
                got_pc    = out_pc;
                got_rd    = wb_rd;
                got_wen   = wb_wen;
                got_req   = dmem_req;
                got_we    = dmem_we;
                got_addr  = dmem_addr;
                got_strb  = dmem_wstrb;
                got_wdata = dmem_wdata;
            end
            next_cycle();
        end
        if (saw_req) begin
            $display("%s: memory request raised for an op without memory access", name_t[r]);
            row_err++;
        end
        compare(name_t[r], "out_pc", pc_t[r], got_pc);
        compare(name_t[r], "wb_rd", xword_t'(rd_t[r]), xword_t'(got_rd));
        compare(name_t[r], "wb_wen", xword_t'(!is_store(op_t[r])), xword_t'(got_wen));
        compare(name_t[r], "dmem_req", xword_t'(is_mem(op_t[r])), xword_t'(got_req));
        compare(name_t[r], "dmem_we", xword_t'(is_store(op_t[r])), xword_t'(got_we));
        if (is_mem(op_t[r])) begin
            compare(name_t[r], "dmem_addr", addr_t[r], got_addr);
        end
        if (is_store(op_t[r])) begin
            compare(name_t[r], "wstrb", xword_t'(exp_strb_t[r]), xword_t'(got_strb));
            compare(name_t[r], "wdata", exp_wdata_t[r], got_wdata);
        end else begin
            compare(name_t[r], "wb_data", exp_data_t[r], got_data);
        end
        if (row_err != 0) begin
            fails++;
        end
        $display("%-16s %s", name_t[r], (row_err == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_op         = OP_NONE;
        in_rd         = '0;
        in_rs2        = '0;
        in_alu_result = '0;
        in_src2       = '0;
        out_ready     = 1'b0;
        fwd_wen       = 1'b0;
        fwd_rd        = '0;
        fwd_data      = '0;
        dmem_ready    = 1'b0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            for (int b = 0; b < STRB_W; b++) begin
                mem[w][8*b +: 8] = fill_byte(xword_t'(8*w + b));
            end
        end
        build_table();
        cycle_limit = n_rows * 20 + 4;  // reset cycles on top
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("tests %0d, passed %0d, failed %0d", n_rows, n_rows - fails, fails);
        if (fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
